// File: Makefile
# Verilator build and run of the interconnect testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "test passed"; \
	else \
	  echo "test failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: ic_apb_regs.sv
`timescale 1ns/1ps
`include "ic_params.svh"

module ic_apb_regs import ic_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  apb_req_t   apb_req_i,
  output apb_rsp_t   apb_rsp_o,
  output logic       inj_val_o,
  output data_t      inj_o,
  input  logic       inj_rdy_i,
  input  logic       cap_val_i,
  input  data_t      cap_i,
  output logic       cap_rdy_o,
  input  xbar_ctrl_t xbar_ctl_i
);

  logic  access;
  logic  wr_inject;
  logic  rd_capture;
  logic  inj_err;
  logic  cap_err;
  logic  inj_full_q;
  data_t inj_q;
  logic  cap_full_q;
  data_t cap_q;

  // ====================
  // bus decode
  // ====================

  assign access     = apb_req_i.psel & apb_req_i.penable;
  assign wr_inject  = access & apb_req_i.pwrite & (apb_req_i.paddr == `IC_REG_INJECT);
  assign rd_capture = access & ~apb_req_i.pwrite & (apb_req_i.paddr == `IC_REG_CAPTURE);

  // overflow and underflow are refused
  assign inj_err = wr_inject & inj_full_q;
  assign cap_err = rd_capture & ~cap_full_q;

  // no wait states
  assign apb_rsp_o.pready  = access;
  assign apb_rsp_o.pslverr = inj_err | cap_err;

  always_comb begin
    apb_rsp_o.prdata = '0;
    case (apb_req_i.paddr)
      `IC_REG_INJECT:  apb_rsp_o.prdata = {{(`IC_APB_DATA_W-`IC_DATA_W){1'b0}}, inj_q};
      `IC_REG_CAPTURE: begin
        if (cap_full_q) begin
          apb_rsp_o.prdata = {{(`IC_APB_DATA_W-`IC_DATA_W){cap_q[`IC_DATA_W-1]}}, cap_q};
        end
      end
      `IC_REG_STATUS:  apb_rsp_o.prdata = {{(`IC_APB_DATA_W-4){1'b0}}, xbar_ctl_i,
                                           cap_full_q, inj_full_q};
      default:         apb_rsp_o.prdata = '0;
    endcase
  end

  // ====================
  // inject holding reg
  // ====================

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      inj_full_q <= 1'b0;
    end else if (wr_inject & ~inj_full_q) begin
      inj_full_q <= 1'b1;
    end else if (inj_rdy_i) begin
      inj_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_inject & ~inj_full_q) begin
      inj_q <= apb_req_i.pwdata[`IC_DATA_W-1:0];
    end
  end

  assign inj_val_o = inj_full_q;
  assign inj_o     = inj_q;

  // ====================
  // capture reg
  // ====================

  assign cap_rdy_o = ~cap_full_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cap_full_q <= 1'b0;
    end else if (cap_val_i & ~cap_full_q) begin
      cap_full_q <= 1'b1;
    end else if (rd_capture) begin
      cap_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cap_val_i & ~cap_full_q) begin
      cap_q <= cap_i;
    end
  end

endmodule

// File: ic_arbiter.sv
`timescale 1ns/1ps
`include "ic_params.svh"

module ic_arbiter import ic_pkg::*; (
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  logic    in0_val_i,
  input  data_t   in0_i,
  output logic    in0_rdy_o,
  input  logic    in1_val_i,
  input  data_t   in1_i,
  output logic    in1_rdy_o,
  output logic    out_val_o,
  output ic_msg_t out_msg_o,
  input  logic    out_rdy_i
);

  logic    full_q;
  ic_msg_t msg_q;
  ic_msg_t win_msg;
  logic    can_load;
  logic    load;

  // register free now or emptied this cycle
  assign can_load = ~full_q | out_rdy_i;

  // input 0 has fixed priority
  assign in0_rdy_o = can_load;
  assign in1_rdy_o = can_load & ~in0_val_i;
  assign load      = can_load & (in0_val_i | in1_val_i);

  // tag winner with the address of its source
  always_comb begin
    if (in0_val_i) begin
      win_msg.addr = `IC_ADDR_XBAR_DATA;
      win_msg.data = in0_i;
    end else begin
      win_msg.addr = `IC_ADDR_LOOPBACK;
      win_msg.data = in1_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (out_rdy_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      msg_q <= win_msg;
    end
  end

  assign out_val_o = full_q;
  assign out_msg_o = msg_q;

endmodule

// File: ic_params.svh
`ifndef IC_PARAMS_SVH
`define IC_PARAMS_SVH

// stream widths
`define IC_ADDR_W        4
`define IC_DATA_W        16
`define IC_XBAR_CTRL_W   2

// router destinations
`define IC_ADDR_XBAR_DATA  4'd0
`define IC_ADDR_XBAR_CTRL  4'd1
`define IC_ADDR_LOOPBACK   4'd9

// apb bus and register map
`define IC_APB_ADDR_W    8
`define IC_APB_DATA_W    32
`define IC_REG_INJECT    8'h00
`define IC_REG_CAPTURE   8'h04
`define IC_REG_STATUS    8'h08

`endif

// File: ic_pkg.sv
`include "ic_params.svh"

package ic_pkg;

  typedef logic [`IC_ADDR_W-1:0]      addr_t;
  typedef logic [`IC_DATA_W-1:0]      data_t;
  // input index * 2 + output index
  typedef logic [`IC_XBAR_CTRL_W-1:0] xbar_ctrl_t;
  typedef logic [`IC_APB_ADDR_W-1:0]  apb_addr_t;
  typedef logic [`IC_APB_DATA_W-1:0]  apb_data_t;

  typedef struct packed {
    addr_t addr;
    data_t data;
  } ic_msg_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

endpackage

// File: ic_router.sv
`timescale 1ns/1ps
`include "ic_params.svh"

module ic_router import ic_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       in_val_i,
  input  ic_msg_t    in_msg_i,
  output logic       in_rdy_o,
  output logic       xdat_val_o,
  output data_t      xdat_o,
  input  logic       xdat_rdy_i,
  output logic       xctl_val_o,
  output xbar_ctrl_t xctl_o,
  input  logic       xctl_rdy_i,
  output logic       loop_val_o,
  output data_t      loop_o,
  input  logic       loop_rdy_i
);

  // one-hot destination with bit 0 xbar data, bit 1 xbar ctrl and bit 2 loopback
  logic [2:0] dest_d;
  logic [2:0] dest_q;
  logic       full_q;
  data_t      data_q;
  logic       out_rdy;
  logic       drain;
  logic       accept;

  // unknown addresses decode to no destination
  assign dest_d[0] = (in_msg_i.addr == `IC_ADDR_XBAR_DATA);
  assign dest_d[1] = (in_msg_i.addr == `IC_ADDR_XBAR_CTRL);
  assign dest_d[2] = (in_msg_i.addr == `IC_ADDR_LOOPBACK);

  assign out_rdy = (dest_q[0] & xdat_rdy_i) |
                   (dest_q[1] & xctl_rdy_i) |
                   (dest_q[2] & loop_rdy_i);
  assign drain    = full_q & out_rdy;
  assign in_rdy_o = ~full_q | drain;
  assign accept   = in_val_i & in_rdy_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
      dest_q <= '0;
    end else if (accept) begin
      // discarded messages leave the register empty
      full_q <= |dest_d;
      dest_q <= dest_d;
    end else if (drain) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      data_q <= in_msg_i.data;
    end
  end

  assign xdat_val_o = full_q & dest_q[0];
  assign xctl_val_o = full_q & dest_q[1];
  assign loop_val_o = full_q & dest_q[2];
  assign xdat_o     = data_q;
  assign xctl_o     = data_q[`IC_XBAR_CTRL_W-1:0];
  assign loop_o     = data_q;

endmodule

// File: ic_top.sv
`timescale 1ns/1ps
`include "ic_params.svh"

module ic_top import ic_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     in_val_i,
  input  ic_msg_t  in_msg_i,
  output logic     in_rdy_o,
  output logic     out_val_o,
  output ic_msg_t  out_msg_o,
  input  logic     out_rdy_i,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o
);

  // router to xbar and arbiter
  logic       xdat_val;
  logic       xdat_rdy;
  data_t      xdat;
  logic       xctl_val;
  logic       xctl_rdy;
  xbar_ctrl_t xctl;
  logic       loop_val;
  logic       loop_rdy;
  data_t      loop;

  // register block side of the xbar
  logic       inj_val;
  logic       inj_rdy;
  data_t      inj;
  logic       cap_val;
  logic       cap_rdy;
  data_t      cap;
  xbar_ctrl_t xbar_ctl;

  // xbar output 0 into the arbiter
  logic       xout_val;
  logic       xout_rdy;
  data_t      xout;

  ic_router i_router (
    .clk_i, .arst_n_i, .in_val_i, .in_msg_i, .in_rdy_o,
    .xdat_val_o(xdat_val), .xdat_o(xdat), .xdat_rdy_i(xdat_rdy),
    .xctl_val_o(xctl_val), .xctl_o(xctl), .xctl_rdy_i(xctl_rdy),
    .loop_val_o(loop_val), .loop_o(loop), .loop_rdy_i(loop_rdy)
  );

  ic_xbar i_xbar (
    .clk_i, .arst_n_i,
    .ctl_val_i(xctl_val), .ctl_i(xctl), .ctl_rdy_o(xctl_rdy), .ctl_o(xbar_ctl),
    .in0_val_i(xdat_val), .in0_i(xdat), .in0_rdy_o(xdat_rdy),
    .in1_val_i(inj_val), .in1_i(inj), .in1_rdy_o(inj_rdy),
    .out0_val_o(xout_val), .out0_o(xout), .out0_rdy_i(xout_rdy),
    .out1_val_o(cap_val), .out1_o(cap), .out1_rdy_i(cap_rdy)
  );

  ic_arbiter i_arbiter (
    .clk_i, .arst_n_i,
    .in0_val_i(xout_val), .in0_i(xout), .in0_rdy_o(xout_rdy),
    .in1_val_i(loop_val), .in1_i(loop), .in1_rdy_o(loop_rdy),
    .out_val_o, .out_msg_o, .out_rdy_i
  );

  ic_apb_regs i_apb_regs (
    .clk_i, .arst_n_i, .apb_req_i, .apb_rsp_o,
    .inj_val_o(inj_val), .inj_o(inj), .inj_rdy_i(inj_rdy),
    .cap_val_i(cap_val), .cap_i(cap), .cap_rdy_o(cap_rdy),
    .xbar_ctl_i(xbar_ctl)
  );

endmodule

// File: ic_xbar.sv
`timescale 1ns/1ps
`include "ic_params.svh"

module ic_xbar import ic_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       ctl_val_i,
  input  xbar_ctrl_t ctl_i,
  output logic       ctl_rdy_o,
  output xbar_ctrl_t ctl_o,
  input  logic       in0_val_i,
  input  data_t      in0_i,
  output logic       in0_rdy_o,
  input  logic       in1_val_i,
  input  data_t      in1_i,
  output logic       in1_rdy_o,
  output logic       out0_val_o,
  output data_t      out0_o,
  input  logic       out0_rdy_i,
  output logic       out1_val_o,
  output data_t      out1_o,
  input  logic       out1_rdy_i
);

  xbar_ctrl_t ctrl_q;
  logic       in_sel;
  logic       out_sel;
  logic       sel_val;
  data_t      sel_dat;
  logic       sel_rdy;

  // ====================
  // control register
  // ====================

  // control is always accepted
  assign ctl_rdy_o = 1'b1;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_q <= '0;
    end else if (ctl_val_i) begin
      ctrl_q <= ctl_i;
    end
  end

  assign ctl_o = ctrl_q;

  // ====================
  // data path
  // ====================

  // upper bit picks the input, lower bit the output
  assign in_sel  = ctrl_q[1];
  assign out_sel = ctrl_q[0];

  assign sel_val = in_sel ? in1_val_i : in0_val_i;
  assign sel_dat = in_sel ? in1_i : in0_i;
  assign sel_rdy = out_sel ? out1_rdy_i : out0_rdy_i;

  // unselected inputs stay blocked
  assign in0_rdy_o = ~in_sel & sel_rdy;
  assign in1_rdy_o = in_sel & sel_rdy;

  assign out0_val_o = ~out_sel & sel_val;
  assign out1_val_o = out_sel & sel_val;
  assign out0_o     = sel_dat;
  assign out1_o     = sel_dat;

endmodule

// File: tb.f
+incdir+.
ic_pkg.sv
ic_router.sv
ic_xbar.sv
ic_arbiter.sv
ic_apb_regs.sv
ic_top.sv
tb_clk_gen.sv
tb_top.sv

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 5
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release shortly after a rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #10;
    arst_n_o = 1'b1;
  end

endmodule

// File: tb_top.sv
`timescale 1ns/1ps
`include "ic_params.svh"

module tb_top import ic_pkg::*; ();

  localparam int N_DEFAULT = 16;
  localparam int N_LOOP    = 8;
  localparam int N_BP      = 40;
  // stream messages plus a margin for apb accesses and polls
  localparam int N_ITEMS   = N_DEFAULT + 3 * N_LOOP + N_BP + 30;
  localparam logic [31:0] SEED = 32'he8de883d;

  localparam logic [1:0] DEST_NONE = 2'd0;
  localparam logic [1:0] DEST_OUT0 = 2'd1;
  localparam logic [1:0] DEST_OUT9 = 2'd2;
  localparam logic [1:0] DEST_CAP  = 2'd3;

  localparam int RDY_ON     = 0;
  localparam int RDY_RANDOM = 1;
  localparam int RDY_OFF    = 2;

  typedef struct packed {
    logic [1:0] dest;
    apb_data_t  value;
  } expect_t;

  logic       clk;
  logic       arst_n;
  logic       in_val;
  ic_msg_t    in_msg;
  logic       in_rdy;
  logic       out_val;
  ic_msg_t    out_msg;
  logic       out_rdy;
  apb_req_t   apb_req;
  apb_rsp_t   apb_rsp;

  data_t      exp_q0[$];
  data_t      exp_q9[$];
  apb_data_t  exp_cap[$];
  xbar_ctrl_t model_ctrl;
  int         rdy_mode = RDY_ON;
  int         err_cnt = 0;
  int         chk_cnt = 0;
  int         cmp_err_cnt = 0;
  int         cmp_chk_cnt = 0;

  tb_clk_gen i_clk_gen (
    .clk_o(clk),
    .arst_n_o(arst_n)
  );

  ic_top i_dut (
    .clk_i(clk), .arst_n_i(arst_n),
    .in_val_i(in_val), .in_msg_i(in_msg), .in_rdy_o(in_rdy),
    .out_val_o(out_val), .out_msg_o(out_msg), .out_rdy_i(out_rdy),
    .apb_req_i(apb_req), .apb_rsp_o(apb_rsp)
  );

  // ====================
  // reference model
  // ====================

  // where a stream message or inject write ends up, and with what value
  function automatic expect_t predict(input logic from_apb, input addr_t addr,
                                      input data_t data, input xbar_ctrl_t ctrl);
    expect_t e;
    logic    to_xbar;
    logic    in_idx;
    e.dest  = DEST_NONE;
    e.value = apb_data_t'(data);
    to_xbar = from_apb || (addr == `IC_ADDR_XBAR_DATA);
    in_idx  = from_apb;
    if (!from_apb && addr == `IC_ADDR_LOOPBACK) begin
      e.dest = DEST_OUT9;
    end
    // upper control bit picks the input, lower bit the output
    if (to_xbar && ctrl[1] == in_idx) begin
      if (ctrl[0]) begin
        e.dest = DEST_CAP;
        // payload read as a signed number
        if (data[`IC_DATA_W-1]) begin
          e.value = e.value - (apb_data_t'(1) << `IC_DATA_W);
        end
      end else begin
        e.dest = DEST_OUT0;
      end
    end
    return e;
  endfunction

  task automatic push_expect(input expect_t e);
    case (e.dest)
      DEST_OUT0: exp_q0.push_back(e.value[`IC_DATA_W-1:0]);
      DEST_OUT9: exp_q9.push_back(e.value[`IC_DATA_W-1:0]);
      DEST_CAP:  exp_cap.push_back(e.value);
      default:   ;
    endcase
  endtask

  task automatic check_val(input string what, input apb_data_t got, input apb_data_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ====================
  // bus drivers
  // ====================

  task automatic send_msg(input addr_t addr, input data_t data);
    logic rdy;
    push_expect(predict(1'b0, addr, data, model_ctrl));
    if (addr == `IC_ADDR_XBAR_CTRL) begin
      model_ctrl = data[`IC_XBAR_CTRL_W-1:0];
    end
    in_val      = 1'b1;
    in_msg.addr = addr;
    in_msg.data = data;
    do begin
      @(negedge clk);
      rdy = in_rdy;
      @(posedge clk);
    end while (!rdy);
    #10;
    in_val = 1'b0;
  endtask

  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                          output apb_data_t rdata, output logic slverr);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #10;
    apb_req.penable = 1'b1;
    @(negedge clk);
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    check_val("pready in access phase", apb_data_t'(apb_rsp.pready), 32'd1);
    @(posedge clk);
    #10;
    apb_req = '0;
  endtask

  task automatic wait_status(input apb_data_t mask, input apb_data_t value);
    apb_data_t rd;
    logic      err;
    do begin
      apb_xfer(1'b0, `IC_REG_STATUS, '0, rd, err);
    end while ((rd & mask) != value);
  endtask

  task automatic wait_drain();
    while (exp_q0.size() != 0 || exp_q9.size() != 0) begin
      @(posedge clk);
      #10;
    end
  endtask

  // output ready is always on, random or held off
  initial begin : drive_out_rdy
    int mode;
    out_rdy = 1'b1;
    forever begin
      @(posedge clk);
      mode = rdy_mode;
      #10;
      case (mode)
        RDY_RANDOM: out_rdy = 1'($urandom_range(1, 0));
        RDY_OFF:    out_rdy = 1'b0;
        default:    out_rdy = 1'b1;
      endcase
    end
  end

  // ====================
  // comparison
  // ====================

  always @(negedge clk) begin : compare_out
    data_t     exp_d;
    apb_data_t exp_w;
    logic      known;
    if (arst_n && out_val && out_rdy) begin
      cmp_chk_cnt++;
      known = 1'b1;
      if (out_msg.addr == `IC_ADDR_XBAR_DATA && exp_q0.size() != 0) begin
        exp_d = exp_q0.pop_front();
      end else if (out_msg.addr == `IC_ADDR_LOOPBACK && exp_q9.size() != 0) begin
        exp_d = exp_q9.pop_front();
      end else begin
        known = 1'b0;
      end
      if (!known) begin
        cmp_err_cnt++;
        $display("ERR %0t: unexpected output tag %0d data %h", $time, out_msg.addr,
                 out_msg.data);
      end else if (out_msg.data !== exp_d) begin
        cmp_err_cnt++;
        $display("ERR %0t: output tag %0d data %h, expected %h", $time, out_msg.addr,
                 out_msg.data, exp_d);
      end
    end
    // successful capture reads
    if (apb_req.psel && apb_req.penable && !apb_req.pwrite &&
        apb_req.paddr == `IC_REG_CAPTURE && !apb_rsp.pslverr) begin
      cmp_chk_cnt++;
      if (exp_cap.size() == 0) begin
        cmp_err_cnt++;
        $display("ERR %0t: CAPTURE read %h with nothing captured", $time, apb_rsp.prdata);
      end else begin
        exp_w = exp_cap.pop_front();
        if (apb_rsp.prdata !== exp_w) begin
          cmp_err_cnt++;
          $display("ERR %0t: CAPTURE read %h, expected %h", $time, apb_rsp.prdata, exp_w);
        end
      end
    end
  end

  initial begin : watchdog
    repeat (N_ITEMS * 40 + 200) @(posedge clk);
    $display("run did not finish within %0d clock periods", N_ITEMS * 40 + 200);
    $display("Simulation failed");
    $finish;
  end

  // ====================
  // test sequence
  // ====================

  initial begin : main
    apb_data_t rd;
    apb_data_t w;
    logic      err;
    addr_t     a;
    data_t     d;
    in_val     = 1'b0;
    in_msg     = '0;
    apb_req    = '0;
    model_ctrl = '0;
    void'($urandom(SEED));
    @(posedge arst_n);
    @(posedge clk);
    #10;

    // after reset
    @(negedge clk);
    check_val("out_val_o after reset", apb_data_t'(out_val), '0);
    check_val("in_rdy_o after reset", apb_data_t'(in_rdy), 32'd1);
    check_val("pready when idle", apb_data_t'(apb_rsp.pready), '0);
    check_val("pslverr when idle", apb_data_t'(apb_rsp.pslverr), '0);
    @(posedge clk);
    #10;
    apb_xfer(1'b0, `IC_REG_STATUS, '0, rd, err);
    check_val("STATUS after reset", rd, '0);

    // default route
    for (int i = 0; i < N_DEFAULT; i++) begin
      send_msg(`IC_ADDR_XBAR_DATA, data_t'($urandom()));
    end
    wait_drain();

    // loopback, discard, then ordinary traffic again
    for (int i = 0; i < N_LOOP; i++) begin
      send_msg(`IC_ADDR_LOOPBACK, data_t'($urandom()));
      a = addr_t'(2 + $urandom_range(12, 0));
      if (a >= `IC_ADDR_LOOPBACK) begin
        a = a + 4'd1;
      end
      send_msg(a, data_t'($urandom()));
      send_msg(`IC_ADDR_XBAR_DATA, data_t'($urandom()));
    end
    wait_drain();

    // capture one negative and one positive value through xbar output 1
    send_msg(`IC_ADDR_XBAR_CTRL, data_t'(1));
    for (int i = 0; i < 2; i++) begin
      d = data_t'($urandom());
      d[`IC_DATA_W-1] = (i == 0);
      send_msg(`IC_ADDR_XBAR_DATA, d);
      wait_status(32'h2, 32'h2);
      apb_xfer(1'b0, `IC_REG_STATUS, '0, rd, err);
      check_val("STATUS with capture valid", rd, apb_data_t'({model_ctrl, 1'b1, 1'b0}));
      apb_xfer(1'b0, `IC_REG_CAPTURE, '0, rd, err);
      check_val("pslverr on CAPTURE read", apb_data_t'(err), '0);
    end
    apb_xfer(1'b0, `IC_REG_CAPTURE, '0, rd, err);
    check_val("pslverr on empty CAPTURE read", apb_data_t'(err), 32'd1);

    // inject through xbar input 1 with the output stalled so the register stays full
    send_msg(`IC_ADDR_XBAR_CTRL, data_t'(2));
    wait_status(32'hc, 32'h8);
    rdy_mode = RDY_OFF;
    for (int i = 0; i < 2; i++) begin
      w = $urandom();
      push_expect(predict(1'b1, '0, w[`IC_DATA_W-1:0], model_ctrl));
      apb_xfer(1'b1, `IC_REG_INJECT, w, rd, err);
      check_val("pslverr on INJECT write", apb_data_t'(err), '0);
    end
    wait_status(32'h1, 32'h1);
    apb_xfer(1'b0, `IC_REG_STATUS, '0, rd, err);
    check_val("STATUS with inject full", rd, apb_data_t'({model_ctrl, 1'b0, 1'b1}));
    apb_xfer(1'b1, `IC_REG_INJECT, $urandom(), rd, err);
    check_val("pslverr on INJECT while full", apb_data_t'(err), 32'd1);
    rdy_mode = RDY_ON;
    wait_drain();
    send_msg(`IC_ADDR_XBAR_CTRL, data_t'(0));

    // random back-pressure with mixed sources
    rdy_mode = RDY_RANDOM;
    for (int i = 0; i < N_BP; i++) begin
      if ($urandom_range(1, 0) == 0) begin
        a = `IC_ADDR_XBAR_DATA;
      end else begin
        a = `IC_ADDR_LOOPBACK;
      end
      send_msg(a, data_t'($urandom()));
    end
    wait_drain();
    rdy_mode = RDY_ON;
    repeat (4) @(posedge clk);

    if (exp_q0.size() != 0 || exp_q9.size() != 0 || exp_cap.size() != 0) begin
      err_cnt++;
      $display("%0d output messages and %0d captures were expected but never arrived",
               exp_q0.size() + exp_q9.size(), exp_cap.size());
    end
    $display("checks: %0d, errors: %0d", chk_cnt + cmp_chk_cnt, err_cnt + cmp_err_cnt);
    if (err_cnt + cmp_err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
